/* all.f */
+incdir+include
logic/tile_video_pkg.sv
logic/raster_counter.sv
logic/fetch_sequencer.sv
logic/tile_line_builder.sv
logic/plane_compositor.sv
logic/tile_plane_renderer.sv
verification/tb_clock_gen.sv
verification/tb_vram_model.sv
verification/tb_tile_plane_renderer.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f all.f --top-module tb_tile_plane_renderer -Mdir obj_dir

./obj_dir/Vtb_tile_plane_renderer | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi
echo "simulation finished without failure"

/* verification/tb_tile_plane_renderer.sv */
// Tile plane renderer testbench
// Runs two frames against a random VRAM image and checks every output
// pixel, the raster shape, reset values and the frame_drawn level.

`timescale 1ns/10ps

module tb_tile_plane_renderer;

    localparam int TIMEOUT_CYCLES = 22 * 525 * 286 / 10;   // 2.2 frames

    logic        vga_clk;
    logic        reset;
    logic [7:0]  vram8_q;
    logic [31:0] vram32_q;
    logic [13:0] vram8_addr;
    logic [13:0] vram32_addr;
    logic [7:0]  rgb;
    logic        de;
    logic        hsync_n;
    logic        vsync_n;
    logic        frame_drawn;

    int   err_reset = 0, err_raster = 0, err_pixel = 0;
    int   bg_checks = 0, win_checks = 0, blank_checks = 0;
    int   x = 0, line_idx = -1, lines_in_frame = 0, frames_seen = 0;
    int   hs_low = 0, vs_low = 0, cycles = 0;
    logic prev_de = 1'b0, prev_hs = 1'b1, prev_vs = 1'b1;
    logic seen_active = 1'b0, run_done = 1'b0, timed_out = 1'b0;

    tb_clock_gen clk_gen (
        .o_clk   (vga_clk),
        .o_reset (reset)
    );

    tb_vram_model vram (
        .i_clk    (vga_clk),
        .i_addr8  (vram8_addr),
        .i_addr32 (vram32_addr),
        .o_q8     (vram8_q),
        .o_q32    (vram32_q)
    );

    tile_plane_renderer i_dut (
        .vga_clk       (vga_clk),
        .i_reset       (reset),
        .i_vram8_q     (vram8_q),
        .i_vram32_q    (vram32_q),
        .o_vram8_addr  (vram8_addr),
        .o_vram32_addr (vram32_addr),
        .o_rgb         (rgb),
        .o_de          (de),
        .o_hsync_n     (hsync_n),
        .o_vsync_n     (vsync_n),
        .o_frame_drawn (frame_drawn)
    );

    task automatic check_eq(input int cat, input string test, input int expected,
                            input int actual);
        assert (expected == actual) else begin
            case (cat)
                0:       err_reset++;
                1:       err_raster++;
                default: err_pixel++;
            endcase
            $display("ERR %s expected %0h actual %0h (frame %0d line %0d x %0d)",
                     test, expected, actual, frames_seen, line_idx, x);
        end
    endtask

    // color of one plane at screen pixel (px, py) straight from the VRAM image
    function automatic logic [7:0] plane_pixel_color(input int map_base, input int color_base,
                                                     input int stride, input int px,
                                                     input int py);
        int          entry;
        int          tile;
        int          cidx;
        int          code;
        logic [31:0] pat_word;
        logic [15:0] half;
        logic [31:0] pal;
        entry    = (py / 8) * stride + px / 8;
        tile     = int'(vram.mem8[14'(map_base + entry)]);
        cidx     = int'(vram.mem8[14'(color_base + entry)]);
        pat_word = vram.mem32[14'(tile * 4 + (py % 8) / 2)];
        half     = ((py % 8) % 2 == 1) ? pat_word[31:16] : pat_word[15:0];
        code     = 32'(half >> (14 - 2 * (px % 8))) & 3;   // pixel 0 in top pair
        pal      = vram.mem32[14'(1024 + cidx)];
        return 8'(pal >> (24 - 8 * code));
    endfunction

    task automatic check_pixel();
        logic [7:0] bg_exp;
        logic [7:0] win_exp;
        if (line_idx >= 256) begin
            check_eq(2, "blank_rows_rgb", 0, int'(rgb));
            check_eq(2, "frame_drawn_high", 1, int'(frame_drawn));
            blank_checks++;
        end else begin
            bg_exp  = plane_pixel_color(0, 2048, 64, x, line_idx);
            win_exp = plane_pixel_color(4096, 6144, 60, x, line_idx);
            check_eq(2, "frame_drawn_low", 0, int'(frame_drawn));
            if (win_exp != 8'h00) begin
                check_eq(2, "window", int'(win_exp), int'(rgb));
                win_checks++;
            end else begin
                check_eq(2, "background", int'(bg_exp), int'(rgb));
                bg_checks++;
            end
        end
    endtask

    always @(negedge vga_clk) begin
        if (reset) begin
            // de, frame_drawn, hsync_n, vsync_n, rgb
            check_eq(0, "reset_outputs", 'h300,
                     int'({de, frame_drawn, hsync_n, vsync_n, rgb}));
            check_eq(0, "reset_vram_addr", 0, int'({vram8_addr, vram32_addr}));
        end else begin
            if (!seen_active && !de)
                check_eq(0, "pre_active_outputs", 0, int'({frame_drawn, rgb}));
            if (!hsync_n) begin
                hs_low++;
            end else if (!prev_hs) begin
                check_eq(1, "hsync_width", 41, hs_low);
                hs_low = 0;
            end
            if (!vsync_n) begin
                vs_low++;
                if (prev_vs) begin      // new frame
                    if (frames_seen > 0)
                        check_eq(1, "frame_lines", 272, lines_in_frame);
                    frames_seen++;
                    lines_in_frame = 0;
                    line_idx       = -1;
                    if (frames_seen == 3)
                        run_done = 1'b1;
                end
            end else if (!prev_vs) begin
                check_eq(1, "vsync_width", 10 * 525, vs_low);
                vs_low = 0;
            end
            if (de && !prev_de) begin
                line_idx++;
                lines_in_frame++;
                x           = 0;
                seen_active = 1'b1;
            end
            if (de) begin
                check_pixel();
                x++;
            end else begin
                check_eq(1, "blank_rgb", 0, int'(rgb));
                if (prev_de)
                    check_eq(1, "line_pixels", 480, x);
            end
        end
        prev_de = de;
        prev_hs = hsync_n;
        prev_vs = vsync_n;
    end

    always @(posedge vga_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            timed_out = 1'b1;
    end

    initial begin : finish_run
        int missing;
        int total;
        wait (run_done || timed_out);
        missing = 0;
        assert (bg_checks > 0) else begin
            missing++;
            $display("no background pixel was checked");
        end
        assert (win_checks > 0) else begin
            missing++;
            $display("no window pixel was checked");
        end
        assert (blank_checks > 0) else begin
            missing++;
            $display("no pixel of the blank rows 256 to 271 was checked");
        end
        if (timed_out)
            $display("timeout: second frame not finished after %0d cycles", TIMEOUT_CYCLES);
        total = err_reset + err_raster + err_pixel + missing + int'(timed_out);
        $display("errors: reset=%0d raster=%0d pixel=%0d coverage=%0d timeout=%0d total=%0d",
                 err_reset, err_raster, err_pixel, missing, int'(timed_out), total);
        if (total == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* verification/tb_vram_model.sv */
// VRAM model
// Byte and word memories with one cycle of read latency, read data
// driven 1 ns after the clock edge. Contents come from an LCG, seed 67.

`timescale 1ns/10ps

module tb_vram_model (
    input  logic        i_clk,
    input  logic [13:0] i_addr8,
    input  logic [13:0] i_addr32,
    output logic [7:0]  o_q8,
    output logic [31:0] o_q32
);

    localparam int DEPTH = 16384;

    logic [7:0]  mem8  [0:DEPTH-1];
    logic [31:0] mem32 [0:DEPTH-1];
    logic [31:0] lcg_state;
    logic [31:0] pal_word;
    logic [7:0]  color;
    logic [13:0] rd8;
    logic [13:0] rd32;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // top byte only, low LCG bits repeat quickly
    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[31:24];
    endfunction

    initial begin
        lcg_state = 32'd67;
        o_q8      = '0;
        o_q32     = '0;
        for (int a = 0; a < DEPTH; a++) begin
            mem8[14'(a)]  = rand_byte();    // tile and color indices
            mem32[14'(a)] = {rand_byte(), rand_byte(), rand_byte(), rand_byte()};
        end
        // palettes, roughly one color in four is transparent black
        for (int a = 1024; a < 1280; a++) begin
            for (int k = 0; k < 4; k++) begin
                color = rand_byte();
                if (color[1:0] == 2'b00)
                    color = 8'h00;
                pal_word = {pal_word[23:0], color};
            end
            mem32[14'(a)] = pal_word;
        end
        forever begin
            @(posedge i_clk);
            rd8  = i_addr8;
            rd32 = i_addr32;
            #1;
            o_q8  = mem8[rd8];
            o_q32 = mem32[rd32];
        end
    end

endmodule

/* verification/tb_clock_gen.sv */
// Testbench clock and reset
// 40 ns vga_clk, reset held for the first 16 rising edges

`timescale 1ns/10ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (16) @(posedge o_clk);
        #1 o_reset = 1'b0;      // released just after the edge
    end

endmodule

/* logic/tile_plane_renderer.sv */
// Tile plane renderer
// Background and window tile planes for a 480x272 RGB332 panel,
// fed from a byte VRAM and a word VRAM with one cycle of read latency.

`timescale 1ns/10ps
`include "tile_video_defines.svh"

module tile_plane_renderer (
    input  logic                         vga_clk,
    input  logic                         i_reset,
    input  logic [7:0]                   i_vram8_q,
    input  logic [31:0]                  i_vram32_q,
    output logic [`VRAM_ADDR_W-1:0]      o_vram8_addr,
    output logic [`VRAM_ADDR_W-1:0]      o_vram32_addr,
    output tile_video_pkg::rgb332_t      o_rgb,
    output logic                         o_de,
    output logic                         o_hsync_n,
    output logic                         o_vsync_n,
    output logic                         o_frame_drawn
);

    tile_video_pkg::raster_pos_t pos;
    tile_video_pkg::fetch_slot_t slot;
    tile_video_pkg::rgb332_t     bg_pixel;
    tile_video_pkg::rgb332_t     win_pixel;
    logic                        fetch_go;
    logic                        fetch_end;

    raster_counter u_raster (
        .i_vga_clk   (vga_clk),
        .i_reset     (i_reset),
        .o_pos       (pos),
        .o_fetch_go  (fetch_go),
        .o_fetch_end (fetch_end)
    );

    fetch_sequencer u_fetch (
        .i_vga_clk     (vga_clk),
        .i_reset       (i_reset),
        .i_pos         (pos),
        .i_fetch_go    (fetch_go),
        .i_fetch_end   (fetch_end),
        .i_vram8_q     (i_vram8_q),
        .o_slot        (slot),
        .o_vram8_addr  (o_vram8_addr),
        .o_vram32_addr (o_vram32_addr)
    );

    tile_line_builder u_lines (
        .i_vga_clk   (vga_clk),
        .i_reset     (i_reset),
        .i_pos       (pos),
        .i_slot      (slot),
        .i_vram32_q  (i_vram32_q),
        .o_bg_pixel  (bg_pixel),
        .o_win_pixel (win_pixel)
    );

    plane_compositor u_comp (
        .i_vga_clk     (vga_clk),
        .i_reset       (i_reset),
        .i_pos         (pos),
        .i_bg_pixel    (bg_pixel),
        .i_win_pixel   (win_pixel),
        .o_rgb         (o_rgb),
        .o_de          (o_de),
        .o_hsync_n     (o_hsync_n),
        .o_vsync_n     (o_vsync_n),
        .o_frame_drawn (o_frame_drawn)
    );

endmodule

/* logic/plane_compositor.sv */
// Plane compositor
// Window over background with black outside the drawn area. Registers
// the pixel together with the syncs so all outputs share one latency.

`timescale 1ns/10ps
`include "tile_video_defines.svh"

module plane_compositor (
    input  logic                         i_vga_clk,
    input  logic                         i_reset,
    input  tile_video_pkg::raster_pos_t  i_pos,
    input  tile_video_pkg::rgb332_t      i_bg_pixel,
    input  tile_video_pkg::rgb332_t      i_win_pixel,
    output tile_video_pkg::rgb332_t      o_rgb,
    output logic                         o_de,
    output logic                         o_hsync_n,
    output logic                         o_vsync_n,
    output logic                         o_frame_drawn
);

    logic below_rows;   // tile rows past the map

    assign below_rows = i_pos.tile_row >= 6'(`TILE_ROWS_SHOWN);

    always_ff @(posedge i_vga_clk) begin
        if (i_reset) begin
            o_rgb         <= '0;
            o_de          <= 1'b0;
            o_hsync_n     <= 1'b1;
            o_vsync_n     <= 1'b1;
            o_frame_drawn <= 1'b0;
        end else begin
            if (!i_pos.active || below_rows)
                o_rgb <= '0;
            else
                o_rgb <= (i_win_pixel != '0) ? i_win_pixel : i_bg_pixel;
            o_de          <= i_pos.active;
            o_hsync_n     <= i_pos.h_sync_n;
            o_vsync_n     <= i_pos.v_sync_n;
            o_frame_drawn <= i_pos.visible_line >= 9'(`TILE_ROWS_SHOWN * 8);    // lines 256..271
        end
    end

endmodule

/* logic/tile_line_builder.sv */
// Tile line builder
// Captures pattern halves and palettes from word VRAM and expands them
// into 8-pixel color lines. Serves the pixel for the current column.

`timescale 1ns/10ps

module tile_line_builder (
    input  logic                         i_vga_clk,
    input  logic                         i_reset,
    input  tile_video_pkg::raster_pos_t  i_pos,
    input  tile_video_pkg::fetch_slot_t  i_slot,
    input  tile_video_pkg::vram_word_u   i_vram32_q,
    output tile_video_pkg::rgb332_t      o_bg_pixel,
    output tile_video_pkg::rgb332_t      o_win_pixel
);

    logic [15:0]                   bg_pat_q;
    logic [15:0]                   win_pat_q;
    logic [15:0]                   pat_half;
    tile_video_pkg::rgb332_t [7:0] bg_next_q;
    tile_video_pkg::rgb332_t [7:0] win_next;
    tile_video_pkg::rgb332_t [7:0] bg_cur_q;
    tile_video_pkg::rgb332_t [7:0] win_cur_q;

    // pixel 0 sits in the top bit pair, code 0 picks palette bits 31:24
    function automatic logic [63:0] expand_line(input logic [15:0] pat,
                                                input tile_video_pkg::vram_word_u word);
        tile_video_pkg::rgb332_t [7:0] line;
        logic [1:0]                    code;
        for (int p = 0; p < 8; p++) begin
            code    = pat[15 - 2*p -: 2];
            line[p] = word.palette[2'd3 - code];
        end
        return line;
    endfunction

    assign pat_half = i_pos.line_in_tile[0] ? i_vram32_q.pattern.odd_line
                                            : i_vram32_q.pattern.even_line;

    // window palette lands in the BG_TILE slot, so its next line is not held
    assign win_next = expand_line(win_pat_q, i_vram32_q);

    always_ff @(posedge i_vga_clk) begin
        case (i_slot)
            tile_video_pkg::BG_COLOR:  bg_pat_q  <= pat_half;
            tile_video_pkg::WIN_COLOR: win_pat_q <= pat_half;
            tile_video_pkg::WIN_TILE:  bg_next_q <= expand_line(bg_pat_q, i_vram32_q);
            default: ;
        endcase
    end

    always_ff @(posedge i_vga_clk) begin
        if (i_reset) begin
            bg_cur_q  <= '0;
            win_cur_q <= '0;
        end else if (i_slot == tile_video_pkg::BG_TILE) begin
            bg_cur_q  <= bg_next_q;
            win_cur_q <= win_next;
        end
    end

    assign o_bg_pixel  = bg_cur_q[i_pos.pixel_in_tile];
    assign o_win_pixel = win_cur_q[i_pos.pixel_in_tile];

endmodule

/* logic/fetch_sequencer.sv */
// Fetch sequencer
// Eight-slot state machine per tile. Drives the byte VRAM map lookups
// for the next column and chains the returned bytes into word VRAM reads.

`timescale 1ns/10ps
`include "tile_video_defines.svh"

module fetch_sequencer (
    input  logic                             i_vga_clk,
    input  logic                             i_reset,
    input  tile_video_pkg::raster_pos_t      i_pos,
    input  logic                             i_fetch_go,
    input  logic                             i_fetch_end,
    input  logic [7:0]                       i_vram8_q,
    output tile_video_pkg::fetch_slot_t      o_slot,
    output logic [`VRAM_ADDR_W-1:0]          o_vram8_addr,
    output logic [`VRAM_ADDR_W-1:0]          o_vram32_addr
);

    localparam int AW = `VRAM_ADDR_W;

    tile_video_pkg::fetch_slot_t slot_q;
    tile_video_pkg::fetch_slot_t slot_d;
    logic [5:0]                  col_q;     // column being fetched
    logic [AW-1:0]               bg_entry;
    logic [AW-1:0]               win_entry;
    logic [AW-1:0]               pattern_addr;
    logic [AW-1:0]               palette_addr;

    always_comb begin
        slot_d = slot_q;
        if (i_fetch_go) begin
            slot_d = tile_video_pkg::BG_TILE;
        end else if (i_fetch_end) begin
            slot_d = tile_video_pkg::FETCH_IDLE;
        end else begin
            case (slot_q)
                tile_video_pkg::BG_TILE:     slot_d = tile_video_pkg::BG_PATTERN;
                tile_video_pkg::BG_PATTERN:  slot_d = tile_video_pkg::BG_COLOR;
                tile_video_pkg::BG_COLOR:    slot_d = tile_video_pkg::BG_PALETTE;
                tile_video_pkg::BG_PALETTE:  slot_d = tile_video_pkg::WIN_TILE;
                tile_video_pkg::WIN_TILE:    slot_d = tile_video_pkg::WIN_PATTERN;
                tile_video_pkg::WIN_PATTERN: slot_d = tile_video_pkg::WIN_COLOR;
                tile_video_pkg::WIN_COLOR:   slot_d = tile_video_pkg::WIN_PALETTE;
                tile_video_pkg::WIN_PALETTE: slot_d = tile_video_pkg::BG_TILE;
                default:                     slot_d = tile_video_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_vga_clk) begin
        if (i_reset) begin
            slot_q <= tile_video_pkg::FETCH_IDLE;
            col_q  <= '0;
        end else begin
            slot_q <= slot_d;
            if (i_fetch_go) begin
                col_q <= '0;
            end else if (slot_q == tile_video_pkg::WIN_PALETTE) begin
                col_q <= col_q + 6'd1;
            end
        end
    end

    assign bg_entry     = AW'(i_pos.tile_row * `BG_MAP_STRIDE) + AW'(col_q);
    assign win_entry    = AW'(i_pos.tile_row * `WIN_MAP_STRIDE) + AW'(col_q);
    assign pattern_addr = AW'({i_vram8_q, 2'b00}) + AW'(i_pos.line_in_tile[2:1]);
    assign palette_addr = AW'(`PALETTE_BASE) + AW'(i_vram8_q);  // byte is the color index

    always_comb begin
        o_vram8_addr  = '0;
        o_vram32_addr = '0;
        case (slot_q)
            tile_video_pkg::BG_TILE:     o_vram8_addr  = AW'(`BG_TILE_BASE) + bg_entry;
            tile_video_pkg::BG_COLOR:    o_vram8_addr  = AW'(`BG_COLOR_BASE) + bg_entry;
            tile_video_pkg::WIN_TILE:    o_vram8_addr  = AW'(`WIN_TILE_BASE) + win_entry;
            tile_video_pkg::WIN_COLOR:   o_vram8_addr  = AW'(`WIN_COLOR_BASE) + win_entry;
            tile_video_pkg::BG_PATTERN,
            tile_video_pkg::WIN_PATTERN: o_vram32_addr = pattern_addr;
            tile_video_pkg::BG_PALETTE,
            tile_video_pkg::WIN_PALETTE: o_vram32_addr = palette_addr;
            default: ;
        endcase
    end

    assign o_slot = slot_q;

endmodule

/* logic/raster_counter.sv */
// Raster counter
// Pixel and line counters for the 480x272 panel. Produces the sync
// levels, data enable, tile coordinates and the per-line fetch window.

`timescale 1ns/10ps
`include "tile_video_defines.svh"

module raster_counter (
    input  logic                        i_vga_clk,
    input  logic                        i_reset,
    output tile_video_pkg::raster_pos_t o_pos,
    output logic                        o_fetch_go,
    output logic                        o_fetch_end
);

    logic [9:0] h_count;
    logic [8:0] v_count;
    logic       h_active;
    logic       v_active;
    logic       fetch_line;
    logic [8:0] px;
    logic [8:0] line;

    always_ff @(posedge i_vga_clk) begin
        if (i_reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == 10'(`H_TOTAL - 1)) begin
            h_count <= '0;
            v_count <= (v_count == 9'(`V_TOTAL - 1)) ? '0 : v_count + 9'd1;
        end else begin
            h_count <= h_count + 10'd1;
        end
    end

    assign h_active = h_count >= 10'(`H_ACT_START);
    assign v_active = v_count >= 9'(`V_ACT_START);
    assign px       = h_active ? 9'(h_count - 10'(`H_ACT_START)) : '0;
    assign line     = v_active ? v_count - 9'(`V_ACT_START) : '0;

    assign o_pos.h_sync_n      = !(h_count >= 10'(`H_FP) &&
                                   h_count < 10'(`H_FP + `H_SYNC));
    assign o_pos.v_sync_n      = !(v_count >= 9'(`V_FP) &&
                                   v_count < 9'(`V_FP + `V_SYNC));
    assign o_pos.active        = h_active && v_active;
    assign o_pos.tile_col      = px[8:3];
    assign o_pos.pixel_in_tile = px[2:0];
    assign o_pos.tile_row      = line[8:3];
    assign o_pos.line_in_tile  = line[2:0];
    assign o_pos.visible_line  = line;

    // only rows that get drawn need tiles
    assign fetch_line = v_active && (line[8:3] < 6'(`TILE_ROWS_SHOWN));

    // one extra cycle since the sequencer registers its first slot
    assign o_fetch_go  = fetch_line &&
                         (h_count == 10'(`H_ACT_START - `FETCH_LEAD - 1));
    assign o_fetch_end = fetch_line && (h_count >= 10'(`H_TOTAL - 2));

endmodule

/* logic/tile_video_pkg.sv */
// Tile video controller types
// Raster position, fetch slots and the two views of a word VRAM entry

package tile_video_pkg;

    typedef struct packed {
        logic       h_sync_n;
        logic       v_sync_n;
        logic       active;         // data enable
        logic [5:0] tile_col;
        logic [2:0] pixel_in_tile;
        logic [5:0] tile_row;
        logic [2:0] line_in_tile;
        logic [8:0] visible_line;   // zero outside active lines
    } raster_pos_t;

    typedef enum logic [3:0] {
        FETCH_IDLE,
        BG_TILE,
        BG_PATTERN,
        BG_COLOR,
        BG_PALETTE,
        WIN_TILE,
        WIN_PATTERN,
        WIN_COLOR,
        WIN_PALETTE
    } fetch_slot_t;

    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } rgb332_t;

    typedef union packed {
        struct packed {
            logic [15:0] odd_line;
            logic [15:0] even_line;
        } pattern;
        rgb332_t [3:0] palette;     // entry 3 is bits 31:24
    } vram_word_u;

endpackage

/* include/tile_video_defines.svh */
// Tile video controller constants
// Raster timing for the 480x272 panel, VRAM address map and widths

`ifndef TILE_VIDEO_DEFINES_SVH
`define TILE_VIDEO_DEFINES_SVH

`define H_RES           480
`define H_FP            2
`define H_SYNC          41
`define H_BP            2
`define H_ACT_START     (`H_FP + `H_SYNC + `H_BP)
`define H_TOTAL         (`H_ACT_START + `H_RES)     // 525 clocks per line

`define V_RES           272
`define V_FP            2
`define V_SYNC          10
`define V_BP            2
`define V_ACT_START     (`V_FP + `V_SYNC + `V_BP)
`define V_TOTAL         (`V_ACT_START + `V_RES)     // 286 lines per frame

`define TILE_ROWS_SHOWN 32
`define BG_MAP_STRIDE   64
`define WIN_MAP_STRIDE  60

`define BG_TILE_BASE    0
`define BG_COLOR_BASE   2048
`define WIN_TILE_BASE   4096
`define WIN_COLOR_BASE  6144
`define PALETTE_BASE    1024                        // word VRAM

`define VRAM_ADDR_W     14
`define FETCH_LEAD      9                           // first slot to first pixel

`endif
